//--- io_unit_stimulus.txt
# op addr data expected, hex; W expects {o_spi_cs, o_gpo}, R expects o_bus_q
# P sets pins with data {nint, gpi}; T triggers with data N, expects an interrupt mask
P 0 5 0
R C02737 0 5
R C0272D 0 0
W C02737 A0 1A
R C02737 0 A5
P 0 13 0
R C0272D 0 1
W C0272C 0 0A
R C0272C 0 0
W C0272C 1 1A
R C0272C 0 1
W C00000 FF 1A
R C00000 0 0
W C0272B 5A 1A
R C0272B 0 5A
W C02739 3 1A
T C0273A 3 1
W C0273B 0 1A
T C0273C 0 2
W C0273D C 1A
T C0273E C 4

//--- tb.f
mmio_map_pkg.sv
periph_pkg.sv
os_timer.sv
spi_byte_master.sv
io_bus_control.sv
io_unit_top.sv
tb_io_unit.sv

//--- Bender.yml
package:
  name: io_unit

sources:
  - files:
      - mmio_map_pkg.sv
      - periph_pkg.sv
      - os_timer.sv
      - spi_byte_master.sv
      - io_bus_control.sv
      - io_unit_top.sv
  - target: test
    files:
      - tb_io_unit.sv

//--- tb_io_unit.sv
/*
 * Testbench of the memory-mapped I/O unit
 *  - clock, reset and cycle-counter timeout
 *  - stimulus file reader and bus driver
 *  - interrupt pulse monitor and value checks
 */
`timescale 1ns/1ps

module tb_io_unit;
    import mmio_map_pkg::*;

    logic      clk;
    logic      reset;
    bus_addr_t bus_addr;
    bus_data_t bus_data;
    logic      bus_we;
    logic      bus_start;
    bus_data_t bus_q;
    logic      bus_done;
    gpio_t     gpi;
    gpio_t     gpo;
    logic      spi_clk;
    logic      spi_mosi;
    logic      spi_cs;
    logic      spi_nint;
    logic [2:0] ost_int;

    int        cycle = 0;
    int        limit = 1000000;
    int        pulse_cnt [3];
    int        pulse_cyc [3];

    byte       op_q [$];
    bus_addr_t addr_q [$];
    bus_data_t data_q [$];
    bus_data_t exp_q [$];

    io_unit_top #(
        .SPI_HALF_BIT (2),
        .TIMER_WIDTH  (32)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .i_bus_addr  (bus_addr),
        .i_bus_data  (bus_data),
        .i_bus_we    (bus_we),
        .i_bus_start (bus_start),
        .o_bus_q     (bus_q),
        .o_bus_done  (bus_done),
        .i_gpi       (gpi),
        .o_gpo       (gpo),
        .o_spi_clk   (spi_clk),
        .o_spi_mosi  (spi_mosi),
        .i_spi_miso  (spi_mosi),
        .o_spi_cs    (spi_cs),
        .i_spi_nint  (spi_nint),
        .o_ost_int   (ost_int)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Cycle count, timeout, interrupt monitor
    // ----------------------------------------
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= limit)
        begin
            $display("Timeout: the run took more than %0d clock cycles", limit);
            $display("Simulation FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // Sampled mid-cycle where cycle holds the number of the last rising edge
    always @(negedge clk)
    begin
        for (int n = 0; n < 3; n++)
        begin
            if (ost_int[n])
            begin
                pulse_cnt[n] = pulse_cnt[n] + 1;
                pulse_cyc[n] = cycle;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Runs one access and returns read data, edges to done and the first sampling edge
    task automatic bus_access(input bus_addr_t addr, input bus_data_t data, input logic we,
                              output bus_data_t q, output int latency, output int start_edge);
        int cycles;
        begin
            bus_addr  = addr;
            bus_data  = data;
            bus_we    = we;
            bus_start = 1'b1;
            cycles    = 0;
            while (!(cycles > 0 && bus_done))
            begin
                @(posedge clk);
                #1;
                cycles = cycles + 1;
                if (cycles == 1)
                    start_edge = cycle;
            end
            q       = bus_q;
            latency = cycles;
            @(posedge clk);
            #1;
            bus_start = 1'b0;
            bus_we    = 1'b0;
            // Start stays low for one cycle plus a random idle gap
            repeat ($urandom % 4 + 1) @(posedge clk);
            #1;
        end
    endtask

    initial
    begin
        int        fd;
        int        latency;
        int        trig;
        string     line;
        byte       op;
        bus_addr_t addr;
        bus_data_t data;
        bus_data_t exp_v;
        bus_data_t q;

        void'($urandom(92));
        reset     = 1'b1;
        bus_addr  = '0;
        bus_data  = '0;
        bus_we    = 1'b0;
        bus_start = 1'b0;
        gpi       = '0;
        spi_nint  = 1'b0;

        fd = $fopen("io_unit_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the stimulus file io_unit_stimulus.txt");
            $display("Simulation FAILED");
            $fatal(1, "No stimulus");
        end
        while (!$feof(fd))
        begin
            if ($fgets(line, fd) > 0 && line.len() > 0 && line[0] != "#")
            begin
                if ($sscanf(line, "%c %h %h %h", op, addr, data, exp_v) == 4)
                begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    data_q.push_back(data);
                    exp_q.push_back(exp_v);
                end
            end
        end
        $fclose(fd);
        limit = 200 * op_q.size() + 100;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("o_bus_done", 0, bus_done);
        check_value("o_bus_q", 0, bus_q);
        check_value("o_spi_cs", 1, spi_cs);
        check_value("o_spi_clk", 0, spi_clk);
        check_value("o_gpo", 0, gpo);
        check_value("o_ost_int", 0, ost_int);

        for (int i = 0; i < op_q.size(); i++)
        begin
            case (op_q[i])
                "P":
                begin
                    gpi      = data_q[i][3:0];
                    spi_nint = data_q[i][4];
                end
                "R":
                begin
                    bus_access(addr_q[i], '0, 1'b0, q, latency, trig);
                    check_value("o_bus_done latency", 2, latency);
                    check_value("o_bus_q", exp_q[i], q);
                end
                "W":
                begin
                    bus_access(addr_q[i], data_q[i], 1'b1, q, latency, trig);
                    if (addr_q[i] != ADDR_SPI_DATA)
                        check_value("o_bus_done latency", 2, latency);
                    check_value("{o_spi_cs, o_gpo}", exp_q[i], {spi_cs, gpo});
                end
                "T":
                begin
                    for (int n = 0; n < 3; n++)
                        pulse_cnt[n] = 0;
                    bus_access(addr_q[i], data_q[i], 1'b1, q, latency, trig);
                    while (cycle < trig + data_q[i] + 3)
                        @(posedge clk);
                    #1;
                    for (int n = 0; n < 3; n++)
                    begin
                        check_value($sformatf("o_ost_int[%0d] pulses", n),
                                    exp_q[i][n], pulse_cnt[n]);
                        if (exp_q[i][n])
                            check_value($sformatf("o_ost_int[%0d] edge", n),
                                        trig + data_q[i] + 1, pulse_cyc[n]);
                    end
                end
                default:
                begin
                    $display("Unknown operation in stimulus line %0d", i);
                    $display("Simulation FAILED");
                    $fatal(1, "Bad stimulus line");
                end
            endcase
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- io_unit_top.sv
/*
 * Memory-mapped I/O unit
 *  - bus controller
 *  - one SPI byte master
 *  - three one-shot OS timers
 */
`timescale 1ns/1ps

module io_unit_top #(
    parameter int SPI_HALF_BIT = periph_pkg::SPI_HALF_BIT_DEF,
    parameter int TIMER_WIDTH  = periph_pkg::TIMER_WIDTH_DEF
) (
    input  logic                    clk,
    input  logic                    reset,

    input  mmio_map_pkg::bus_addr_t i_bus_addr,
    input  mmio_map_pkg::bus_data_t i_bus_data,
    input  logic                    i_bus_we,
    input  logic                    i_bus_start,
    output mmio_map_pkg::bus_data_t o_bus_q,
    output logic                    o_bus_done,

    input  mmio_map_pkg::gpio_t     i_gpi,
    output mmio_map_pkg::gpio_t     o_gpo,
    output logic                    o_spi_clk,
    output logic                    o_spi_mosi,
    input  logic                    i_spi_miso,
    output logic                    o_spi_cs,
    input  logic                    i_spi_nint,
    output logic [2:0]              o_ost_int
);
    import mmio_map_pkg::*;

    logic                   spi_start;
    logic                   spi_done;
    io_byte_t               spi_tx_byte;
    io_byte_t               spi_rx_byte;
    logic [TIMER_WIDTH-1:0] t_value;
    logic [2:0]             t_set;
    logic [2:0]             t_trigger;

    io_bus_control #(
        .TIMER_WIDTH    (TIMER_WIDTH)
    ) u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .i_bus_addr     (i_bus_addr),
        .i_bus_data     (i_bus_data),
        .i_bus_we       (i_bus_we),
        .i_bus_start    (i_bus_start),
        .o_bus_q        (o_bus_q),
        .o_bus_done     (o_bus_done),
        .i_gpi          (i_gpi),
        .i_spi_nint     (i_spi_nint),
        .o_gpo          (o_gpo),
        .o_spi_cs       (o_spi_cs),
        .o_spi_start    (spi_start),
        .o_spi_tx_byte  (spi_tx_byte),
        .i_spi_done     (spi_done),
        .i_spi_rx_byte  (spi_rx_byte),
        .o_t_value      (t_value),
        .o_t_set        (t_set),
        .o_t_trigger    (t_trigger)
    );

    spi_byte_master #(
        .SPI_HALF_BIT   (SPI_HALF_BIT)
    ) u_spi (
        .clk            (clk),
        .reset          (reset),
        .i_start        (spi_start),
        .i_tx_byte      (spi_tx_byte),
        .o_done         (spi_done),
        .o_rx_byte      (spi_rx_byte),
        .o_spi_clk      (o_spi_clk),
        .o_spi_mosi     (o_spi_mosi),
        .i_spi_miso     (i_spi_miso)
    );

    // Timers share the value bus, each has its own set and trigger
    for (genvar n = 0; n < 3; n++)
    begin : g_ost
        os_timer #(
            .TIMER_WIDTH    (TIMER_WIDTH)
        ) u_ost (
            .clk            (clk),
            .reset          (reset),
            .i_value        (t_value),
            .i_set          (t_set[n]),
            .i_trigger      (t_trigger[n]),
            .o_int          (o_ost_int[n])
        );
    end

endmodule

//--- io_bus_control.sv
/*
 * Bus controller of the I/O unit
 *  - address decode of the register window
 *  - two-step done sequencing, SPI write wait
 *  - GPO and SPI chip-select registers
 *  - timer set and trigger pulses
 *  - registered read-data mux
 */
`timescale 1ns/1ps

module io_bus_control #(
    parameter int TIMER_WIDTH = periph_pkg::TIMER_WIDTH_DEF
) (
    input  logic                    clk,
    input  logic                    reset,

    input  mmio_map_pkg::bus_addr_t i_bus_addr,
    input  mmio_map_pkg::bus_data_t i_bus_data,
    input  logic                    i_bus_we,
    input  logic                    i_bus_start,
    output mmio_map_pkg::bus_data_t o_bus_q,
    output logic                    o_bus_done,

    input  mmio_map_pkg::gpio_t     i_gpi,
    input  logic                    i_spi_nint,
    output mmio_map_pkg::gpio_t     o_gpo,
    output logic                    o_spi_cs,

    output logic                    o_spi_start,
    output mmio_map_pkg::io_byte_t  o_spi_tx_byte,
    input  logic                    i_spi_done,
    input  mmio_map_pkg::io_byte_t  i_spi_rx_byte,

    output logic [TIMER_WIDTH-1:0]  o_t_value,
    output logic [2:0]              o_t_set,
    output logic [2:0]              o_t_trigger
);
    import mmio_map_pkg::*;

    io_sel_e   sel;
    bus_data_t q_mux;
    logic      busy;        // access accepted, done not yet seen
    logic      done_d;
    logic      pending;     // done goes out on the next edge
    logic      spi_wait;
    logic      first;
    logic      wr_first;

    // Address decode
    always_comb
    begin
        case (i_bus_addr)
            ADDR_SPI_DATA: sel = SEL_SPI_DATA;
            ADDR_SPI_CS:   sel = SEL_SPI_CS;
            ADDR_SPI_NINT: sel = SEL_SPI_NINT;
            ADDR_GPIO:     sel = SEL_GPIO;
            ADDR_T1_VAL:   sel = SEL_T1_VAL;
            ADDR_T1_CTRL:  sel = SEL_T1_CTRL;
            ADDR_T2_VAL:   sel = SEL_T2_VAL;
            ADDR_T2_CTRL:  sel = SEL_T2_CTRL;
            ADDR_T3_VAL:   sel = SEL_T3_VAL;
            ADDR_T3_CTRL:  sel = SEL_T3_CTRL;
            default:       sel = SEL_NONE;
        endcase
    end

    // Start is ignored in the done cycle and the one after
    assign first    = i_bus_start && !busy && !done_d;
    assign wr_first = first && i_bus_we;

    assign o_spi_start   = wr_first && (sel == SEL_SPI_DATA);
    assign o_spi_tx_byte = i_bus_data[7:0];

    assign o_t_value   = i_bus_data[TIMER_WIDTH-1:0];
    assign o_t_set     = {wr_first && (sel == SEL_T3_VAL),
                          wr_first && (sel == SEL_T2_VAL),
                          wr_first && (sel == SEL_T1_VAL)};
    assign o_t_trigger = {wr_first && (sel == SEL_T3_CTRL),
                          wr_first && (sel == SEL_T2_CTRL),
                          wr_first && (sel == SEL_T1_CTRL)};

    // Read mux, timers and unmapped read as zero
    always_comb
    begin
        q_mux = '0;
        case (sel)
            SEL_SPI_DATA: q_mux[7:0] = i_spi_rx_byte;
            SEL_SPI_CS:   q_mux[0]   = o_spi_cs;
            SEL_SPI_NINT: q_mux[0]   = i_spi_nint;
            SEL_GPIO:     q_mux[7:0] = {o_gpo, i_gpi};
            default:      q_mux      = '0;
        endcase
    end

    // ----------------------------------------
    // Done sequencing and registers
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            done_d     <= 1'b0;
            pending    <= 1'b0;
            spi_wait   <= 1'b0;
            o_bus_done <= 1'b0;
            o_bus_q    <= '0;
            o_gpo      <= '0;
            o_spi_cs   <= 1'b1;
        end
        else
        begin
            done_d     <= o_bus_done;
            o_bus_done <= pending;
            pending    <= 1'b0;

            if (o_bus_done)
                busy <= 1'b0;

            if (first)
            begin
                busy <= 1'b1;
                // SPI writes complete on the shifter's done
                if (o_spi_start)
                    spi_wait <= 1'b1;
                else
                    pending <= 1'b1;
            end

            if (spi_wait && i_spi_done)
            begin
                spi_wait <= 1'b0;
                pending  <= 1'b1;
            end

            if (pending)
                o_bus_q <= q_mux;

            if (wr_first && (sel == SEL_GPIO))
                o_gpo <= i_bus_data[7:4];
            if (wr_first && (sel == SEL_SPI_CS))
                o_spi_cs <= i_bus_data[0];
        end
    end

    // One done per access
    a_done_single: assert property (@(posedge clk) disable iff (reset)
        o_bus_done |=> !o_bus_done);

    // No new byte while the shifter is still busy
    a_spi_no_overlap: assert property (@(posedge clk) disable iff (reset)
        !(o_spi_start && spi_wait));

endmodule

//--- spi_byte_master.sv
/*
 * Byte-wide SPI master
 *  - mode 0, MSB first
 *  - SCLK half period of SPI_HALF_BIT clocks
 *  - start/done handshake, done is a one-cycle pulse
 */
`timescale 1ns/1ps

module spi_byte_master #(
    parameter int SPI_HALF_BIT = periph_pkg::SPI_HALF_BIT_DEF
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_start,
    input  logic [7:0] i_tx_byte,
    output logic       o_done,
    output logic [7:0] o_rx_byte,
    output logic       o_spi_clk,
    output logic       o_spi_mosi,
    input  logic       i_spi_miso
);
    import periph_pkg::*;

    localparam int DIV_W = (SPI_HALF_BIT > 1) ? $clog2(SPI_HALF_BIT) : 1;

    spi_state_e       state;
    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       edge_cnt;     // SCLK edges of the byte, 16 in total
    logic [7:0]       tx_shift;
    logic [7:0]       rx_shift;
    logic             half_tick;
    logic             last_edge;

    assign half_tick  = (div_cnt == DIV_W'(SPI_HALF_BIT - 1));
    assign last_edge  = (state == SPI_SHIFT) && half_tick && (edge_cnt == 4'd15);
    assign o_done     = (state == SPI_DONE);
    assign o_spi_mosi = tx_shift[7];

    // ----------------------------------------
    // Control FSM and SCLK divider
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= SPI_IDLE;
            div_cnt   <= '0;
            edge_cnt  <= '0;
            o_spi_clk <= 1'b0;
            tx_shift  <= '0;
        end
        else
        begin
            case (state)
                SPI_IDLE:
                begin
                    div_cnt  <= '0;
                    edge_cnt <= '0;
                    // MSB lands on mosi ahead of the first rising edge
                    if (i_start)
                    begin
                        tx_shift <= i_tx_byte;
                        state    <= SPI_SHIFT;
                    end
                end
                SPI_SHIFT:
                begin
                    if (half_tick)
                    begin
                        div_cnt   <= '0;
                        o_spi_clk <= ~o_spi_clk;
                        edge_cnt  <= edge_cnt + 4'd1;
                        // Falling edge moves the next bit out
                        if (o_spi_clk)
                            tx_shift <= {tx_shift[6:0], 1'b0};
                        if (last_edge)
                            state <= SPI_DONE;
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                end
                SPI_DONE:
                    state <= SPI_IDLE;
                default:
                    state <= SPI_IDLE;
            endcase
        end
    end

    // Sample miso on rising SCLK, hold the byte after the transfer
    always_ff @(posedge clk)
    begin
        if ((state == SPI_SHIFT) && half_tick && !o_spi_clk)
            rx_shift <= {rx_shift[6:0], i_spi_miso};
        if (last_edge)
            o_rx_byte <= rx_shift;
    end

    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        i_start |-> (state == SPI_IDLE));

endmodule

//--- os_timer.sv
/*
 * One-shot OS timer
 *  - value register written by set
 *  - trigger loads the counter and arms it
 *  - one-cycle interrupt value+1 clocks after trigger
 */
`timescale 1ns/1ps

module os_timer #(
    parameter int TIMER_WIDTH = periph_pkg::TIMER_WIDTH_DEF
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [TIMER_WIDTH-1:0] i_value,
    input  logic                   i_set,
    input  logic                   i_trigger,
    output logic                   o_int
);

    logic [TIMER_WIDTH-1:0] stored;
    logic [TIMER_WIDTH-1:0] count;
    logic                   armed;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stored <= '0;
            armed  <= 1'b0;
            o_int  <= 1'b0;
        end
        else
        begin
            o_int <= 1'b0;

            if (i_set)
                stored <= i_value;

            // Retrigger restarts from the stored value
            if (i_trigger)
            begin
                count <= stored;
                armed <= 1'b1;
            end
            else if (armed)
            begin
                if (count == '0)
                begin
                    o_int <= 1'b1;
                    armed <= 1'b0;
                end
                else
                    count <= count - 1'b1;
            end
        end
    end

    a_int_pulse: assert property (@(posedge clk) disable iff (reset)
        o_int |=> !o_int);

endmodule

//--- periph_pkg.sv
/*
 * Peripheral-side definitions
 *  - default timer width
 *  - default SPI half-bit length in clocks
 *  - SPI shifter FSM states
 */
package periph_pkg;

    // Timer counter width
    localparam int TIMER_WIDTH_DEF  = 32;

    // System clocks per SCLK half period
    localparam int SPI_HALF_BIT_DEF = 2;

    // ----------------------------------------
    // SPI shifter states
    // ----------------------------------------
    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_DONE
    } spi_state_e;

endpackage

//--- mmio_map_pkg.sv
/*
 * I/O window map for the CPU bus
 *  - bus address and data widths
 *  - SPI byte and GPIO nibble types
 *  - decode result enum
 *  - word addresses of every mapped register
 */
package mmio_map_pkg;

    typedef logic [26:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [7:0]  io_byte_t;
    typedef logic [3:0]  gpio_t;

    // Decode results of the register window
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_SPI_DATA,
        SEL_SPI_CS,
        SEL_SPI_NINT,
        SEL_GPIO,
        SEL_T1_VAL,
        SEL_T1_CTRL,
        SEL_T2_VAL,
        SEL_T2_CTRL,
        SEL_T3_VAL,
        SEL_T3_CTRL
    } io_sel_e;

    // ----------------------------------------
    // SPI channel
    // ----------------------------------------
    localparam bus_addr_t ADDR_SPI_DATA = 27'hC0272B;
    localparam bus_addr_t ADDR_SPI_CS   = 27'hC0272C;
    localparam bus_addr_t ADDR_SPI_NINT = 27'hC0272D;

    // GPO in bits 7:4, GPI in bits 3:0
    localparam bus_addr_t ADDR_GPIO     = 27'hC02737;

    // ----------------------------------------
    // OS timers, value then trigger
    // ----------------------------------------
    localparam bus_addr_t ADDR_T1_VAL   = 27'hC02739;
    localparam bus_addr_t ADDR_T1_CTRL  = 27'hC0273A;
    localparam bus_addr_t ADDR_T2_VAL   = 27'hC0273B;
    localparam bus_addr_t ADDR_T2_CTRL  = 27'hC0273C;
    localparam bus_addr_t ADDR_T3_VAL   = 27'hC0273D;
    localparam bus_addr_t ADDR_T3_CTRL  = 27'hC0273E;

endpackage
